/* verif/attn_head_patterns.txt */
// Per row: 4 query elements, then 8 keys of 4 elements each (8-bit two's complement),
// then 8 expected weights (100 is 1.0) and the expected row sum, all hex
// Row 0: mixed scores, one at the cutoff distance of 9
10 20 f0 30  01 02 00 00  02 01 00 01  04 00 01 00  00 02 00 01
02 00 02 00  03 00 00 01  00 00 05 01  01 00 00 01
040 100 010 100 002 080 000 020  2f2
// Row 1: wide spread, scores rounded down by the shift
08 10 00 fc  00 14 00 00  03 00 00 00  01 13 00 00  00 0b 07 00
00 12 00 04  05 0f 00 00  00 0c 00 00  00 14 00 01
100 000 080 000 020 020 001 080  241
// Row 2: different dot products, all equal after scaling
ff 02 03 fc  30 00 00 00  00 00 00 0a  21 00 00 00  00 01 00 0a
28 00 01 00  00 00 02 0c  32 01 00 00  24 00 00 00
100 100 100 100 100 100 100 100  800
// Row 3: emitted with credit returns held back
01 00 00 10  05 00 09 03  ff 00 00 03  00 07 00 01  0f 00 00 04
f0 00 00 04  00 00 00 fb  00 00 00 00  08 00 00 02
080 040 020 100 080 000 010 040  2b0
// Row 4: large negative scores, maximum on the last key
80 64 00 00  28 00 11 00  28 01 00 00  28 02 00 7f  27 00 00 00
29 04 00 00  26 00 80 00  28 ff 00 00  26 01 00 00
000 000 000 000 008 004 000 100  10c
// Row 5: maximum on the first key
10 10 10 10  03 03 03 03  02 02 02 02  05 05 01 00  ff 00 00 00
06 06 00 fe  04 04 04 00  01 01 01 01  03 03 03 02
100 010 080 000 040 100 001 080  351

/* build.f */
common/attn_pkg.sv
rtl/elem_counter.sv
rtl/attn_ctrl_fsm.sv
score/score_mac.sv
softmax/score_row_buffer.sv
softmax/exp2_weight_unit.sv
rtl/attn_head_top.sv
verif/attn_head_tb.sv

/* verif/attn_head_tb.sv */
//*********************************************************************
// Testbench for the attention row with pattern-driven stimulus and credit return
//*********************************************************************
`timescale 1ns/100ps

module attn_head_tb import attn_pkg::*; ();

    localparam int D            = 4;
    localparam int N            = 8;
    localparam int SCORE_SHIFT  = 4;
    localparam int OUT_CREDITS  = 4;
    localparam int ROWS         = 6;
    localparam int ROW_LEN      = D + N * D + N + 1;   // Query, keys, weights, sum
    localparam int W_OFS        = D + N * D;
    localparam int PAT_WORDS    = ROWS * ROW_LEN;
    localparam int HOLD_ROW     = 3;    // Row emitted with credit returns held back
    localparam int HOLD_CYCLES  = 20;
    localparam int TIMEOUT      = 1000; // Cycles per wait
    localparam int RUN_LIMIT    = 20000;
    localparam logic [31:0] SEED = 32'd2603;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    elem_t   in_data;
    logic    in_ready;
    logic    out_valid;
    weight_t out_weight;
    sum_t    out_sum;
    logic    out_last;
    logic    credit_return;

    logic [15:0] pat_mem [PAT_WORDS];
    logic [31:0] gap_rng;
    logic [31:0] cred_rng;
    int          owed;        // Beats received but not yet credited back
    logic        hold;
    logic        rows_done;

    attn_head_top #(
        .D(D),
        .N(N),
        .SCORE_SHIFT(SCORE_SHIFT),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_attn_head_top (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_weight(out_weight),
        .out_sum(out_sum),
        .out_last(out_last),
        .credit_return(credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // One input beat after a random idle gap of 0 to 2 cycles
    task automatic send_elem(input logic [7:0] value);
        int gap;
        int waited;
        gap_rng = xorshift32(gap_rng);
        gap = int'(gap_rng % 3);
        if (gap > 0) begin
            in_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        in_valid = 1'b1;
        in_data  = elem_t'(value);
        waited   = 0;
        while (!in_ready) begin   // in_ready holds still until the next rising edge
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: in_ready stayed low for %0d cycles", TIMEOUT);
                abort_run();
            end
        end
        @(negedge clk);   // Beat taken at the edge just passed
    endtask

    task automatic drive_rows();
        int r;
        int i;
        for (r = 0; r < ROWS; r++) begin
            for (i = 0; i < W_OFS; i++)
                send_elem(pat_mem[r * ROW_LEN + i][7:0]);
        end
        in_valid = 1'b0;
    endtask

    // Credits held back, so nothing may come out
    task automatic expect_no_beats(input int r);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value(out_valid, 1'b0,
                        $sformatf("row %0d beat beyond the credit limit", r));
        end
        hold = 1'b0;
    endtask

    task automatic collect_row(input int r);
        int          k;
        int          idle;
        int          base;
        logic [31:0] run_sum;
        k       = 0;
        idle    = 0;
        base    = r * ROW_LEN + W_OFS;
        run_sum = '0;
        while (k < N) begin
            @(negedge clk);
            if (out_valid) begin
                idle    = 0;
                run_sum = run_sum + pat_mem[base + k];
                check_value(out_weight, pat_mem[base + k],
                            $sformatf("row %0d weight %0d", r, k));
                check_value(out_sum, run_sum, $sformatf("row %0d running sum %0d", r, k));
                check_value(out_last, (k == N - 1), $sformatf("row %0d out_last %0d", r, k));
                if (k == N - 1)
                    check_value(out_sum, pat_mem[base + N], $sformatf("row %0d sum", r));
                owed++;
                k++;
                if (hold && (k == OUT_CREDITS))
                    expect_no_beats(r);
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("Timeout: row %0d stalled after %0d of %0d weights", r, k, N);
                    abort_run();
                end
            end
        end
    endtask

    // Full credit before the held row starts
    task automatic wait_credits_settled();
        int waited;
        waited = 0;
        while (owed != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout: %0d credits were never returned", owed);
                abort_run();
            end
        end
    endtask

    task automatic collect_rows();
        int r;
        for (r = 0; r < ROWS; r++) begin
            if (r == HOLD_ROW) begin
                wait_credits_settled();
                hold = 1'b1;
            end
            collect_row(r);
        end
        rows_done = 1'b1;
    endtask

    task automatic return_credits();
        int cycles;
        cycles = 0;
        while (!rows_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("Timeout: run exceeded %0d cycles", RUN_LIMIT);
                abort_run();
            end
            cred_rng = xorshift32(cred_rng);
            if ((owed > 0) && !hold && (cred_rng[1:0] != 2'b00)) begin
                credit_return = 1'b1;
                owed--;
            end else begin
                credit_return = 1'b0;
            end
        end
        credit_return = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        credit_return = 1'b0;
        owed          = 0;
        hold          = 1'b0;
        rows_done     = 1'b0;
        gap_rng       = SEED;
        cred_rng      = xorshift32(SEED);
        $readmemh("verif/attn_head_patterns.txt", pat_mem);
        if (^pat_mem[PAT_WORDS - 1] === 1'bx) begin
            $display("Pattern file is missing or holds fewer than %0d values", PAT_WORDS);
            abort_run();
        end

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(out_last, 1'b0, "out_last after reset");
        check_value(in_ready, 1'b1, "in_ready after reset");

        fork
            drive_rows();
            collect_rows();
            return_credits();
        join

        $display("Verification passed");
        $finish;
    end

endmodule

/* rtl/attn_head_top.sv */
//*********************************************************************
// Attention row top level wiring the controller, index counter, MAC,
// row buffer and exp2 unit
//*********************************************************************
`timescale 1ns/100ps

module attn_head_top import attn_pkg::*; #(
    parameter int D           = 4,
    parameter int N           = 8,
    parameter int SCORE_SHIFT = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  elem_t   in_data,
    output logic    in_ready,
    output logic    out_valid,
    output weight_t out_weight,
    output sum_t    out_sum,
    output logic    out_last,
    input  logic    credit_return
);
    localparam int EW = (D > 1) ? $clog2(D) : 1;
    localparam int KW = (N > 1) ? $clog2(N) : 1;

    ctrl_state_t   phase;
    logic          count_en;
    logic          issue;
    logic [EW-1:0] elem_idx;
    logic [KW-1:0] key_idx;
    logic          elem_last;
    logic          key_last;
    logic          score_valid;
    score_t        score;
    logic          rd_valid;
    score_t        rd_score;
    logic          rd_last;
    score_t        row_max;

    attn_ctrl_fsm #(
        .N(N),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(in_valid),
        .elem_last(elem_last),
        .key_last(key_last),
        .score_valid(score_valid),
        .credit_return(credit_return),
        .phase(phase),
        .in_ready(in_ready),
        .count_en(count_en),
        .issue(issue)
    );

    elem_counter #(
        .D(D),
        .N(N)
    ) i_counter (
        .clk(clk),
        .rst_n(rst_n),
        .count_en(count_en),
        .phase(phase),
        .elem_idx(elem_idx),
        .key_idx(key_idx),
        .elem_last(elem_last),
        .key_last(key_last)
    );

    score_mac #(
        .D(D),
        .SCORE_SHIFT(SCORE_SHIFT)
    ) i_score_mac (
        .clk(clk), .rst_n(rst_n),
        .phase(phase),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .elem_idx(elem_idx),
        .elem_last(elem_last),
        .score_valid(score_valid),
        .score(score)
    );

    score_row_buffer #(
        .N(N)
    ) i_row_buffer (
        .clk(clk), .rst_n(rst_n),
        .phase(phase),
        .score_valid(score_valid),
        .score(score),
        .key_idx(key_idx),
        .issue(issue),
        .rd_valid(rd_valid),
        .rd_score(rd_score),
        .rd_last(rd_last),
        .row_max(row_max)
    );

    exp2_weight_unit i_exp2 (
        .clk(clk), .rst_n(rst_n),
        .rd_valid(rd_valid),
        .rd_score(rd_score),
        .rd_last(rd_last),
        .row_max(row_max),
        .out_valid(out_valid),
        .out_weight(out_weight),
        .out_sum(out_sum),
        .out_last(out_last)
    );

endmodule

/* softmax/exp2_weight_unit.sv */
//*********************************************************************
// Base-2 weight per score relative to the row maximum, running row sum
//*********************************************************************
`timescale 1ns/100ps

module exp2_weight_unit import attn_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    rd_valid,
    input  score_t  rd_score,
    input  logic    rd_last,
    input  score_t  row_max,
    output logic    out_valid,
    output weight_t out_weight,
    output sum_t    out_sum,
    output logic    out_last
);
    localparam weight_t WEIGHT_ONE = 9'd256;
    localparam int      EXP_CUTOFF = 9;   // 256 >> 9 and beyond is zero

    logic signed [SCORE_W:0] diff;   // One extra bit so max minus score never wraps
    weight_t                 w_nxt;
    sum_t                    sum_base;

    assign diff     = row_max - rd_score;
    assign w_nxt    = (diff >= EXP_CUTOFF) ? '0 : (WEIGHT_ONE >> diff);
    assign sum_base = (out_valid && out_last) ? '0 : out_sum;

    always_ff @(posedge clk) begin
        if (rd_valid)
            out_weight <= w_nxt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            out_sum   <= '0;
        end else begin
            out_valid <= rd_valid;
            out_last  <= rd_valid && rd_last;

            // Sum restarts after the last weight of a row
            if (rd_valid)
                out_sum <= sum_base + SUM_W'(w_nxt);
            else if (out_valid && out_last)
                out_sum <= '0;
        end
    end

endmodule

/* softmax/score_row_buffer.sv */
//*********************************************************************
// Row buffer for N scaled scores with a running row maximum
//*********************************************************************
`timescale 1ns/100ps

module score_row_buffer import attn_pkg::*; #(
    parameter int N  = 8,
    localparam int KW = (N > 1) ? $clog2(N) : 1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  ctrl_state_t   phase,
    input  logic          score_valid,
    input  score_t        score,
    input  logic [KW-1:0] key_idx,
    input  logic          issue,
    output logic          rd_valid,
    output score_t        rd_score,
    output logic          rd_last,
    output score_t        row_max
);
    localparam score_t SCORE_MIN = {1'b1, {(SCORE_W - 1){1'b0}}};

    score_t        mem [N];
    logic [KW-1:0] wr_idx;

    // The key index has already moved on when the score of a key comes out
    // of the MAC, so the slot is the one before it
    assign wr_idx = (key_idx == '0) ? KW'(N - 1) : key_idx - 1'b1;

    always_ff @(posedge clk) begin
        if (score_valid)
            mem[wr_idx] <= score;
        if (issue)
            rd_score <= mem[key_idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_last  <= 1'b0;
            row_max  <= SCORE_MIN;
        end else begin
            rd_valid <= issue;
            rd_last  <= issue && (key_idx == KW'(N - 1));

            if (phase == LOAD_Q)
                row_max <= SCORE_MIN;   // New row
            else if (score_valid && (score > row_max))
                row_max <= score;
        end
    end

endmodule

/* score/score_mac.sv */
//*********************************************************************
// Query register and dot-product MAC with arithmetic right-shift scaling
//*********************************************************************
`timescale 1ns/100ps

module score_mac import attn_pkg::*; #(
    parameter int D           = 4,
    parameter int SCORE_SHIFT = 4,
    localparam int EW = (D > 1) ? $clog2(D) : 1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  ctrl_state_t   phase,
    input  logic          in_valid,
    input  logic          in_ready,
    input  elem_t         in_data,
    input  logic [EW-1:0] elem_idx,
    input  logic          elem_last,
    output logic          score_valid,
    output score_t        score
);
    // Full-precision sum of D products plus a guard bit
    localparam int ACC_W = 2 * ELEM_W + $clog2(D) + 1;

    elem_t                     q_reg [D];
    logic                      q_load;
    logic                      k_accept;
    logic signed [2*ELEM_W-1:0] prod;
    logic signed [ACC_W-1:0]   acc;
    logic signed [ACC_W-1:0]   acc_nxt;
    logic signed [ACC_W-1:0]   acc_shr;

    assign q_load   = in_valid && in_ready && (phase == LOAD_Q);
    assign k_accept = in_valid && in_ready && (phase == LOAD_K);

    assign prod    = in_data * q_reg[elem_idx];   // Signed 8x8
    assign acc_nxt = acc + prod;
    assign acc_shr = acc_nxt >>> SCORE_SHIFT;

    always_ff @(posedge clk) begin
        if (q_load)
            q_reg[elem_idx] <= in_data;
        if (k_accept && elem_last)
            score <= acc_shr[SCORE_W-1:0];   // Keep the low SCORE_W bits
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc         <= '0;
            score_valid <= 1'b0;
        end else begin
            score_valid <= k_accept && elem_last;
            if (phase == LOAD_Q)
                acc <= '0;
            else if (k_accept)
                acc <= elem_last ? '0 : acc_nxt;   // Fresh sum for the next key
        end
    end

endmodule

/* rtl/attn_ctrl_fsm.sv */
//*********************************************************************
// Row phase FSM with the output credit counter
//*********************************************************************
`timescale 1ns/100ps

module attn_ctrl_fsm import attn_pkg::*; #(
    parameter int N           = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic        elem_last,
    input  logic        key_last,
    input  logic        score_valid,
    input  logic        credit_return,
    output ctrl_state_t phase,
    output logic        in_ready,
    output logic        count_en,
    output logic        issue
);
    localparam int CW = $clog2(OUT_CREDITS + 1);
    localparam int SW = $clog2(N + 1);

    logic [CW-1:0] credits;
    logic [SW-1:0] score_cnt;   // Scores written so far in this row
    logic          keys_done;   // Last key element taken while its score is still in the MAC
    logic          accept;
    logic          last_score;

    // Input closes once the last key is in, so an early query beat waits
    assign in_ready   = (phase == LOAD_Q) || ((phase == LOAD_K) && !keys_done);
    assign accept     = in_valid && in_ready;
    assign issue      = (phase == EMIT) && (credits != '0);   // Credit taken here
    assign count_en   = (phase == EMIT) ? issue : accept;
    assign last_score = score_valid && (score_cnt == SW'(N - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase     <= LOAD_Q;
            keys_done <= 1'b0;
            score_cnt <= '0;
            credits   <= CW'(OUT_CREDITS);
        end else begin
            credits <= credits + CW'(credit_return) - CW'(issue);

            case (phase)
                LOAD_Q: begin
                    if (accept && elem_last)
                        phase <= LOAD_K;
                end
                LOAD_K: begin
                    if (accept && elem_last && key_last)
                        keys_done <= 1'b1;
                    if (score_valid)
                        score_cnt <= score_cnt + 1'b1;
                    if (last_score) begin   // EMIT starts after the N-th write
                        phase     <= EMIT;
                        keys_done <= 1'b0;
                        score_cnt <= '0;
                    end
                end
                EMIT: begin
                    if (issue && key_last)
                        phase <= DRAIN;
                end
                DRAIN:   phase <= LOAD_Q;   // One idle cycle
                default: phase <= LOAD_Q;
            endcase
        end
    end

endmodule

/* rtl/elem_counter.sv */
//*********************************************************************
// Element and key index counter with wrap flags
//*********************************************************************
`timescale 1ns/100ps

module elem_counter import attn_pkg::*; #(
    parameter int D  = 4,
    parameter int N  = 8,
    localparam int EW = (D > 1) ? $clog2(D) : 1,
    localparam int KW = (N > 1) ? $clog2(N) : 1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          count_en,
    input  ctrl_state_t   phase,
    output logic [EW-1:0] elem_idx,
    output logic [KW-1:0] key_idx,
    output logic          elem_last,
    output logic          key_last
);
    ctrl_state_t   prev_phase;
    logic          phase_chg;
    logic [EW-1:0] elem_q, elem_nxt;
    logic [KW-1:0] key_q, key_nxt;

    // First cycle of a new phase sees both indices at zero
    assign phase_chg = (phase != prev_phase);
    assign elem_idx  = phase_chg ? '0 : elem_q;
    assign key_idx   = phase_chg ? '0 : key_q;
    assign elem_last = (elem_idx == EW'(D - 1));
    assign key_last  = (key_idx == KW'(N - 1));

    always_comb begin
        elem_nxt = elem_idx;
        key_nxt  = key_idx;
        if (count_en) begin
            if (phase == EMIT) begin
                key_nxt = key_last ? '0 : key_idx + 1'b1;   // One read per step
            end else if (elem_last) begin
                elem_nxt = '0;
                key_nxt  = key_last ? '0 : key_idx + 1'b1;
            end else begin
                elem_nxt = elem_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_phase <= LOAD_Q;
            elem_q     <= '0;
            key_q      <= '0;
        end else begin
            prev_phase <= phase;
            elem_q     <= elem_nxt;
            key_q      <= key_nxt;
        end
    end

endmodule

/* common/attn_pkg.sv */
//*********************************************************************
// Attention row package with data widths, payload types and controller phases
//*********************************************************************
package attn_pkg;

    localparam int ELEM_W   = 8;   // Signed query and key elements
    localparam int SCORE_W  = 12;  // Signed scaled dot product
    localparam int WEIGHT_W = 9;   // 256 stands for 1.0
    localparam int SUM_W    = 13;  // Room for N weights of 256

    typedef logic signed [ELEM_W-1:0]  elem_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [WEIGHT_W-1:0]       weight_t;
    typedef logic [SUM_W-1:0]          sum_t;

    // Row phases in the order a row walks through them
    typedef enum logic [1:0] {
        LOAD_Q,
        LOAD_K,
        EMIT,
        DRAIN
    } ctrl_state_t;

endpackage
